//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= pipeRegsTb
RTL_TOP   ?= pipeRegs
OBJ_DIR   ?= obj_dir
EXE       ?= simv
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(EXE)

run: build
	@out="$$(./$(OBJ_DIR)/$(EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/frontStages.sv
module frontStages (
    input  logic                clk,
    input  logic                rst,

    input  pipePkg::fetchPktT   fetchIn,    // from fetch unit
    input  pipePkg::decodePktT  decodeIn,   // from decoder

    input  logic                branchTaken,
    input  logic                stall,
    input  logic                kill,
    input  logic                flush,

    output pipePkg::fetchPktT   fetchOut,   // to decoder
    output pipePkg::decodePktT  decodeOut   // to alu/agu and branch unit
);

    import pipePkg::*;

    logic squash;

    // A taken branch sits in execute, so the two younger instructions behind
    // it are wrong-path. A stalled branch has not resolved yet and must wait.
    assign squash = kill | flush | (branchTaken & ~stall);

    // --------------------
    // fetch / decode
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetchOut <= FETCH_BUBBLE;
        end else if (squash) begin
            fetchOut <= FETCH_BUBBLE;       // clear wins over hold
        end else if (!stall) begin
            fetchOut <= fetchIn;
        end
    end

    // --------------------
    // decode / execute
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decodeOut <= DECODE_BUBBLE;
        end else if (squash) begin
            decodeOut <= DECODE_BUBBLE;
        end else if (!stall) begin
            decodeOut <= decodeIn;
        end
    end

endmodule

//--- logic/memStage.sv
module memStage (
    input  logic              clk,
    input  logic              rst,

    input  pipePkg::execPktT  execIn,   // from alu/agu
    input  logic              stall,
    input  logic              kill,
    input  logic              flush,

    output pipePkg::execPktT  memOut    // address, store data and size to lsu
);

    import pipePkg::*;

    logic clear;

    // no branchTaken here since the branch itself already owns this slot
    assign clear = kill | flush;

    // --------------------
    // execute / memory
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            memOut <= EXEC_BUBBLE;
        end else if (clear) begin
            memOut <= EXEC_BUBBLE;          // drops lsValid with it
        end else if (!stall) begin
            memOut <= execIn;
        end
    end

endmodule

//--- logic/pipePkg.sv
package pipePkg;

    // --------------------
    // widths
    // --------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int EXCEPT_W   = 4;

    typedef logic [XLEN-1:0]       instT;
    typedef logic [XLEN-1:0]       addrT;
    typedef logic [XLEN-1:0]       dataT;
    typedef logic [REG_ADDR_W-1:0] regAddrT;
    typedef logic [CSR_ADDR_W-1:0] csrAddrT;
    typedef logic [EXCEPT_W-1:0]   exceptT;

    // --------------------
    // opcodes
    // --------------------
    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_SLT  = 4'd9,
        ALU_SLTU = 4'd10
    } aluOpE;

    typedef enum logic [2:0] {
        BRU_NONE = 3'd0,
        BRU_BEQ  = 3'd1,
        BRU_BNE  = 3'd2,
        BRU_BLT  = 3'd3,
        BRU_BGE  = 3'd4,
        BRU_JAL  = 3'd5,
        BRU_JALR = 3'd6
    } bruOpE;

    typedef enum logic [2:0] {
        LS_NONE   = 3'd0,
        LS_BYTE   = 3'd1,
        LS_HALF   = 3'd2,
        LS_WORD   = 3'd3,
        LS_BYTE_U = 3'd4,               // lbu
        LS_HALF_U = 3'd5                // lhu
    } lsTypeE;

    // --------------------
    // stage packets
    // --------------------
    typedef struct packed {
        instT inst;
        addrT pc;
    } fetchPktT;

    typedef struct packed {
        fetchPktT fetch;
        dataT     rs1Data;
        dataT     rs2Data;
        dataT     imm;
        logic     rdWe;
        regAddrT  rdAddr;
        logic     csrWe;
        csrAddrT  csrAddr;
        dataT     csrRdata;             // read value for csrrw/csrrs/csrrc
        aluOpE    aluOp;
        bruOpE    bruOp;
        logic     lsValid;
        lsTypeE   lsType;
        exceptT   except;
    } decodePktT;

    typedef struct packed {
        fetchPktT fetch;
        logic     rdWe;
        regAddrT  rdAddr;
        dataT     rdData;               // alu result until load data replaces it
        addrT     memAddr;
        dataT     storeData;
        logic     lsValid;
        lsTypeE   lsType;
        logic     csrWe;
        csrAddrT  csrAddr;
        dataT     csrData;
        exceptT   except;
    } execPktT;

    typedef struct packed {
        fetchPktT fetch;
        logic     rdWe;
        regAddrT  rdAddr;
        dataT     rdData;
        logic     csrWe;
        csrAddrT  csrAddr;
        dataT     csrData;
    } retirePktT;

    // all zeros means no write and every op at its zero member
    localparam fetchPktT  FETCH_BUBBLE  = '0;
    localparam decodePktT DECODE_BUBBLE = '0;
    localparam execPktT   EXEC_BUBBLE   = '0;
    localparam retirePktT RETIRE_BUBBLE = '0;

endpackage

//--- logic/pipeRegs.sv
module pipeRegs (
    input  logic                clk,
    input  logic                rst,

    // --------------------
    // stage inputs
    // --------------------
    input  pipePkg::fetchPktT   fetchIn,
    input  pipePkg::decodePktT  decodeIn,   // built from fetchOut
    input  pipePkg::execPktT    execIn,     // built from decodeOut
    input  pipePkg::retirePktT  retireIn,   // built from memOut

    // --------------------
    // control levels
    // --------------------
    input  logic                branchTaken,
    input  logic                stall,
    input  logic                lsuStallReq,
    input  logic                kill,
    input  logic                flush,

    // --------------------
    // stage outputs
    // --------------------
    output pipePkg::fetchPktT   fetchOut,
    output pipePkg::decodePktT  decodeOut,
    output pipePkg::execPktT    memOut,
    output pipePkg::retirePktT  retireOut
);

    // front end squashed together on a taken branch
    frontStages frontStages_inst (
        .clk         (clk),
        .rst         (rst),
        .fetchIn     (fetchIn),
        .decodeIn    (decodeIn),
        .branchTaken (branchTaken),
        .stall       (stall),
        .kill        (kill),
        .flush       (flush),
        .fetchOut    (fetchOut),
        .decodeOut   (decodeOut)
    );

    // execute to memory
    memStage memStage_inst (
        .clk    (clk),
        .rst    (rst),
        .execIn (execIn),
        .stall  (stall),
        .kill   (kill),
        .flush  (flush),
        .memOut (memOut)
    );

    // memory to writeback that keeps moving for an lsu replay
    retireStage retireStage_inst (
        .clk         (clk),
        .rst         (rst),
        .retireIn    (retireIn),
        .stall       (stall),
        .lsuStallReq (lsuStallReq),
        .kill        (kill),
        .flush       (flush),
        .retireOut   (retireOut)
    );

endmodule

//--- logic/retireStage.sv
module retireStage (
    input  logic                clk,
    input  logic                rst,

    input  pipePkg::retirePktT  retireIn,       // from lsu
    input  logic                stall,
    input  logic                lsuStallReq,    // lsu is waiting on memory
    input  logic                kill,
    input  logic                flush,

    output pipePkg::retirePktT  retireOut       // to register file and csr file
);

    import pipePkg::*;

    logic lsuStallQ;
    logic clear;
    logic load;

    // --------------------
    // lsu request history
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lsuStallQ <= 1'b0;
        end else begin
            lsuStallQ <= lsuStallReq;
        end
    end

    assign clear = kill | flush;

    // The load that raised the stall has its data on retireIn one cycle
    // later, so writeback takes it even though the global stall is still up.
    assign load = ~stall | lsuStallQ;

    // --------------------
    // memory / writeback
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retireOut <= RETIRE_BUBBLE;
        end else if (clear) begin
            retireOut <= RETIRE_BUBBLE;
        end else if (load) begin
            retireOut <= retireIn;          // normal advance or lsu replay
        end
    end

endmodule

//--- project.f
+incdir+include
logic/pipePkg.sv
logic/frontStages.sv
logic/memStage.sv
logic/retireStage.sv
logic/pipeRegs.sv
test/pipeRegsTb.sv

//--- include/pipeChecks.svh
`ifndef PIPE_CHECKS_SVH
`define PIPE_CHECKS_SVH

// --------------------
// error counters
// --------------------
int fetchErrs  = 0;
int decodeErrs = 0;
int execErrs   = 0;
int retireErrs = 0;

// --------------------
// packet compares
// --------------------
task automatic checkFetch(input string tag, input pipePkg::fetchPktT got,
                          input pipePkg::fetchPktT exp);
    if (got !== exp) begin
        fetchErrs++;
        $display("CHECK FAILED %s fetchOut expected %h actual %h at %0t",
                 tag, exp, got, $time);
    end
endtask

task automatic checkDecode(input string tag, input pipePkg::decodePktT got,
                           input pipePkg::decodePktT exp);
    if (got !== exp) begin
        decodeErrs++;
        $display("CHECK FAILED %s decodeOut expected %h actual %h at %0t",
                 tag, exp, got, $time);
    end
endtask

task automatic checkExec(input string tag, input pipePkg::execPktT got,
                         input pipePkg::execPktT exp);
    if (got !== exp) begin
        execErrs++;
        $display("CHECK FAILED %s memOut expected %h actual %h at %0t",
                 tag, exp, got, $time);
    end
endtask

task automatic checkRetire(input string tag, input pipePkg::retirePktT got,
                           input pipePkg::retirePktT exp);
    if (got !== exp) begin
        retireErrs++;
        $display("CHECK FAILED %s retireOut expected %h actual %h at %0t",
                 tag, exp, got, $time);
    end
endtask

`endif

//--- test/pipeRegsTb.sv
module pipeRegsTb;

    timeunit 1ns;
    timeprecision 1ps;

    import pipePkg::*;

    `include "pipeChecks.svh"

    localparam int TEST_CYCLES = 200;               // rough length of all tests
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic      clk;
    logic      rst;
    fetchPktT  fetchIn;
    decodePktT decodeIn;
    execPktT   execIn;
    retirePktT retireIn;
    logic      branchTaken;
    logic      stall;
    logic      lsuStallReq;
    logic      kill;
    logic      flush;
    fetchPktT  fetchOut;
    decodePktT decodeOut;
    execPktT   memOut;
    retirePktT retireOut;

    // expected output of each boundary
    fetchPktT  expFetch;
    decodePktT expDecode;
    execPktT   expExec;
    retirePktT expRetire;

    int cycles = 0;
    int totalErrs;

    pipeRegs pipeRegs_inst (
        .clk         (clk),
        .rst         (rst),
        .fetchIn     (fetchIn),
        .decodeIn    (decodeIn),
        .execIn      (execIn),
        .retireIn    (retireIn),
        .branchTaken (branchTaken),
        .stall       (stall),
        .lsuStallReq (lsuStallReq),
        .kill        (kill),
        .flush       (flush),
        .fetchOut    (fetchOut),
        .decodeOut   (decodeOut),
        .memOut      (memOut),
        .retireOut   (retireOut)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                     // 40 ns period
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic [511:0] randomWide();
        logic [511:0] r;
        r = '0;
        for (int i = 0; i < 16; i++) begin
            r = {r[479:0], $urandom()};
        end
        return r;
    endfunction

    task automatic drawInputs();
        logic [511:0] w;
        w = randomWide();
        fetchIn = w[$bits(fetchPktT)-1:0];
        w = randomWide();
        decodeIn = w[$bits(decodePktT)-1:0];
        w = randomWide();
        execIn = w[$bits(execPktT)-1:0];
        w = randomWide();
        retireIn = w[$bits(retirePktT)-1:0];
    endtask

    task automatic expectInputs();
        expFetch  = fetchIn;                        // one edge of latency
        expDecode = decodeIn;
        expExec   = execIn;
        expRetire = retireIn;
    endtask

    task automatic clearControls();
        branchTaken = 1'b0;
        stall       = 1'b0;
        lsuStallReq = 1'b0;
        kill        = 1'b0;
        flush       = 1'b0;
    endtask

    task automatic advanceCycle();
        @(posedge clk);
        @(negedge clk);                             // outputs settled and inputs may change
    endtask

    task automatic checkOutputs(input string tag);
        checkFetch(tag, fetchOut, expFetch);
        checkDecode(tag, decodeOut, expDecode);
        checkExec(tag, memOut, expExec);
        checkRetire(tag, retireOut, expRetire);
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic resetZeros();
        expFetch  = '0;
        expDecode = '0;
        expExec   = '0;
        expRetire = '0;
        checkOutputs("resetZeros");                 // no edge since release
    endtask

    task automatic passThrough();
        for (int i = 0; i < 8; i++) begin
            drawInputs();
            expectInputs();
            advanceCycle();
            checkOutputs("passThrough");
        end
    endtask

    task automatic stallHold();
        drawInputs();
        expectInputs();
        advanceCycle();
        stall = 1'b1;
        repeat (4) begin
            drawInputs();                           // must be ignored
            advanceCycle();
            checkOutputs("stallHold held");
        end
        stall = 1'b0;
        drawInputs();
        expectInputs();
        advanceCycle();
        checkOutputs("stallHold resume");
    endtask

    task automatic branchSquash();
        drawInputs();
        expectInputs();
        advanceCycle();
        // stalled branch has not resolved so nothing moves
        branchTaken = 1'b1;
        stall = 1'b1;
        drawInputs();
        advanceCycle();
        checkOutputs("branchSquash stalled");
        stall = 1'b0;
        drawInputs();
        expectInputs();
        expFetch  = '0;                             // wrong-path instructions
        expDecode = '0;
        advanceCycle();
        checkOutputs("branchSquash taken");
        clearControls();
    endtask

    task automatic killFlush();
        for (int i = 0; i < 2; i++) begin
            drawInputs();
            expectInputs();
            advanceCycle();
            stall = 1'b1;                           // clear must beat hold
            kill  = (i == 0);
            flush = (i == 1);
            drawInputs();
            expFetch  = '0;
            expDecode = '0;
            expExec   = '0;
            expRetire = '0;
            advanceCycle();
            checkOutputs(i == 0 ? "killFlush kill" : "killFlush flush");
            clearControls();
        end
    endtask

    task automatic lsuReplay();
        drawInputs();
        expectInputs();
        advanceCycle();
        stall = 1'b1;
        lsuStallReq = 1'b1;
        drawInputs();
        advanceCycle();
        checkOutputs("lsuReplay request");          // request not yet remembered
        lsuStallReq = 1'b0;
        drawInputs();
        expRetire = retireIn;                       // load data retires
        advanceCycle();
        checkOutputs("lsuReplay retire");
        drawInputs();
        advanceCycle();
        checkOutputs("lsuReplay hold");
        clearControls();
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        void'($urandom(86));
        rst = 1'b1;
        clearControls();
        fetchIn  = '0;
        decodeIn = '0;
        execIn   = '0;
        retireIn = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        drawInputs();
        rst = 1'b0;
        resetZeros();
        passThrough();
        stallHold();
        branchSquash();
        killFlush();
        lsuReplay();
        totalErrs = fetchErrs + decodeErrs + execErrs + retireErrs;
        $display("errors: fetch %0d decode %0d exec %0d retire %0d total %0d",
                 fetchErrs, decodeErrs, execErrs, retireErrs, totalErrs);
        if (totalErrs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
